// File: source/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    ////////////////////////////////////////
    // cache geometry
    ////////////////////////////////////////
    localparam int LINE_BYTES = 32;
    localparam int WAYS       = 2;
    localparam int SETS       = 64;
    localparam int OFFSET_W   = 5;
    localparam int INDEX_W    = 6;
    localparam int TAG_W      = 21;
    localparam int LINE_W     = LINE_BYTES * 8;
    localparam int BEATS      = 4;
    localparam int BEAT_W     = LINE_W / BEATS;

    // every line transfer is 4 beats of 8 bytes, incrementing
    localparam logic [7:0] BURST_LEN  = 8'd3;
    localparam logic [2:0] BURST_SIZE = 3'd3;
    localparam logic [1:0] BURST_INCR = 2'd1;

    typedef enum logic [2:0] {
        IDLE,
        RD_HIT,
        WR_HIT,
        MISS_AR,
        RELOAD,
        WRITE_BACK,
        ALLOCATE
    } cache_state_e;

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_AW,
        WB_DATA,
        WB_RESP
    } wb_state_e;

    ////////////////////////////////////////
    // port bundles
    ////////////////////////////////////////
    typedef struct packed {
        logic              rd;
        logic              wr;
        logic [31:0]       addr;
        logic [BEAT_W-1:0] wdata;
        logic [7:0]        wmask;
    } cpu_req_t;

    typedef struct packed {
        logic              ready;
        logic              rvalid;
        logic              bvalid;
        logic [BEAT_W-1:0] rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic        arvalid;
        logic [31:0] araddr;
        logic [7:0]  arlen;
        logic [2:0]  arsize;
        logic [1:0]  arburst;
        logic        rready;
    } axi_rd_req_t;

    typedef struct packed {
        logic              arready;
        logic              rvalid;
        logic [BEAT_W-1:0] rdata;
        logic              rlast;
    } axi_rd_rsp_t;

    typedef struct packed {
        logic              awvalid;
        logic [31:0]       awaddr;
        logic [7:0]        awlen;
        logic [2:0]        awsize;
        logic [1:0]        awburst;
        logic              wvalid;
        logic [BEAT_W-1:0] wdata;
        logic [7:0]        wstrb;
        logic              wlast;
        logic              bready;
    } axi_wr_req_t;

    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
    } axi_wr_rsp_t;

endpackage

`default_nettype wire

// File: source/dcache_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_store (
    input  logic                           I_clk,
    input  logic                           I_rst,
    input  logic [31:0]                    lookup_addr,
    input  logic [dcache_pkg::INDEX_W-1:0] op_index,
    input  logic                           op_way,
    input  logic [dcache_pkg::TAG_W-1:0]   alloc_tag,
    input  logic                           alloc_en,
    input  logic                           dirty_set,
    input  logic                           dirty_clr,
    output logic                           hit,
    output logic                           hit_way,
    output logic                           victim_way,
    output logic                           victim_dirty,
    output logic [dcache_pkg::TAG_W-1:0]   victim_tag
);
    import dcache_pkg::*;

    logic [TAG_W-1:0]          tag_mem [SETS][WAYS];
    logic [SETS-1:0][WAYS-1:0] valid_q;
    logic [SETS-1:0][WAYS-1:0] dirty_q;

    logic [TAG_W-1:0]   lk_tag;
    logic [INDEX_W-1:0] lk_index;
    logic               way0_hit;
    logic               way1_hit;

    assign lk_tag   = lookup_addr[31 -: TAG_W];
    assign lk_index = lookup_addr[OFFSET_W +: INDEX_W];

    // compare both ways of the set
    assign way0_hit = valid_q[lk_index][0] && (tag_mem[lk_index][0] == lk_tag);
    assign way1_hit = valid_q[lk_index][1] && (tag_mem[lk_index][1] == lk_tag);
    assign hit      = way0_hit | way1_hit;
    assign hit_way  = way1_hit;

    // way1 on a way1 hit, or on a miss when only way1 is still empty
    assign victim_way = way1_hit
                      | (~hit & valid_q[lk_index][0] & ~valid_q[lk_index][1]);

    assign victim_dirty = dirty_q[lk_index][victim_way];
    assign victim_tag   = tag_mem[lk_index][victim_way];

    always_ff @(posedge I_clk) begin
        if (alloc_en) begin
            tag_mem[op_index][op_way] <= alloc_tag;
        end
    end

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (alloc_en) begin
                valid_q[op_index][op_way] <= 1'b1;
            end
            // a store marks the line, a finished write-back cleans it
            if (dirty_set) begin
                dirty_q[op_index][op_way] <= 1'b1;
            end else if (dirty_clr) begin
                dirty_q[op_index][op_way] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/dcache_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_data_array (
    input  logic                              I_clk,
    input  logic [dcache_pkg::INDEX_W-1:0]    addr,
    input  logic                              way,
    input  logic                              wen,
    input  logic [dcache_pkg::LINE_W-1:0]     wdata,
    input  logic [dcache_pkg::LINE_BYTES-1:0] bmask,
    output logic [dcache_pkg::LINE_W-1:0]     rdata
);
    import dcache_pkg::*;

    // one line per set and way
    logic [LINE_W-1:0] mem [WAYS][SETS];

    // byte lanes, a full mask writes the whole line
    always_ff @(posedge I_clk) begin
        if (wen) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (bmask[b]) begin
                    mem[way][addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // registered read, old data on a same-cycle write
    always_ff @(posedge I_clk) begin
        rdata <= mem[way][addr];
    end

endmodule

`default_nettype wire

// File: source/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  logic                              I_clk,
    input  logic                              I_rst,
    input  dcache_pkg::cpu_req_t              cpu_req,
    output dcache_pkg::cpu_rsp_t              cpu_rsp,
    input  logic                              hit,
    input  logic                              victim_dirty,
    input  logic                              hit_way,
    input  logic                              victim_way,
    input  logic                              refill_done,
    input  logic                              wb_done,
    input  logic [dcache_pkg::LINE_W-1:0]     line_rdata,
    input  logic [dcache_pkg::LINE_W-1:0]     line_buf,
    output logic                              refill_start,
    output logic                              wb_start,
    output logic [31:0]                       refill_addr,
    output logic                              alloc_en,
    output logic                              dirty_set,
    output logic                              dirty_clr,
    output logic [dcache_pkg::INDEX_W-1:0]    arr_addr,
    output logic                              arr_way,
    output logic                              arr_wen,
    output logic [dcache_pkg::LINE_W-1:0]     arr_wdata,
    output logic [dcache_pkg::LINE_BYTES-1:0] arr_bmask,
    output logic [31:0]                       wb_addr,
    input  logic [dcache_pkg::TAG_W-1:0]      victim_tag,
    output logic [31:0]                       lookup_addr,
    output logic [dcache_pkg::INDEX_W-1:0]    op_index,
    output logic                              op_way,
    output logic [dcache_pkg::TAG_W-1:0]      alloc_tag
);
    import dcache_pkg::*;

    cache_state_e state_q;
    cache_state_e state_d;

    logic [31:0]               lat_addr;
    logic                      lat_wr;
    logic [BEAT_W-1:0]         lat_wdata;
    logic [BEAT_W/8-1:0]       lat_wmask;
    logic [$clog2(BEATS)-1:0]  lat_beat;
    logic                      ready;
    logic                      accept;
    logic                      acc_way;
    logic [LINE_BYTES-1:0]     merge_mask;
    logic [LINE_W-1:0]         wide_wdata;
    logic [LINE_W-1:0]         merged_line;
    logic [LINE_W-1:0]         rsp_line;

    assign ready   = (state_q == IDLE) || (state_q == RD_HIT) || (state_q == WR_HIT);
    assign accept  = ready && (cpu_req.rd || cpu_req.wr);
    assign acc_way = hit ? hit_way : victim_way;

    ////////////////////////////////////////
    // request capture
    ////////////////////////////////////////
    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            lat_wr <= 1'b0;
            op_way <= 1'b0;
        end else if (accept) begin
            lat_wr <= cpu_req.wr;
            op_way <= acc_way;
        end
    end

    always_ff @(posedge I_clk) begin
        if (accept) begin
            lat_addr  <= cpu_req.addr;
            lat_wdata <= cpu_req.wdata;
            lat_wmask <= cpu_req.wmask;
        end
    end

    assign lat_beat  = lat_addr[OFFSET_W-1:3];
    assign op_index  = lat_addr[OFFSET_W +: INDEX_W];
    assign alloc_tag = lat_addr[31 -: TAG_W];

    // live address while taking requests, held address during a miss
    assign lookup_addr = ready ? cpu_req.addr : lat_addr;

    ////////////////////////////////////////
    // main FSM
    ////////////////////////////////////////
    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE, RD_HIT, WR_HIT: begin
                if (!accept) begin
                    state_d = IDLE;
                end else if (!hit) begin
                    state_d = MISS_AR;
                end else begin
                    state_d = cpu_req.wr ? WR_HIT : RD_HIT;
                end
            end
            MISS_AR:    state_d = RELOAD;
            RELOAD: begin
                if (refill_done) begin
                    state_d = victim_dirty ? WRITE_BACK : ALLOCATE;
                end
            end
            WRITE_BACK: state_d = wb_done ? ALLOCATE : WRITE_BACK;
            ALLOCATE:   state_d = lat_wr ? WR_HIT : IDLE;
            default:    state_d = IDLE;
        endcase
    end

    // memory side requests
    assign refill_start = (state_q == MISS_AR);
    assign refill_addr  = {lat_addr[31:OFFSET_W], {OFFSET_W{1'b0}}};
    assign wb_start     = (state_q == RELOAD) && refill_done && victim_dirty;
    assign wb_addr      = {victim_tag, op_index, {OFFSET_W{1'b0}}};

    // tag table updates
    assign alloc_en  = (state_q == ALLOCATE);
    assign dirty_set = (state_q == WR_HIT);
    assign dirty_clr = (state_q == WRITE_BACK) && wb_done;

    ////////////////////////////////////////
    // data array port
    ////////////////////////////////////////
    // store bytes of a write miss go into the refilled line
    assign wide_wdata = {BEATS{lat_wdata}};
    assign merge_mask = lat_wr ? ({{(LINE_BYTES-8){1'b0}}, lat_wmask} << {lat_beat, 3'b000})
                               : '0;

    always_comb begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            merged_line[8*b +: 8] = merge_mask[b] ? wide_wdata[8*b +: 8] : line_buf[8*b +: 8];
        end
    end

    // hit writes land in the accept cycle, allocation writes the whole line
    assign arr_addr  = accept ? cpu_req.addr[OFFSET_W +: INDEX_W] : op_index;
    assign arr_way   = accept ? acc_way : op_way;
    assign arr_wen   = (accept && cpu_req.wr && hit) || alloc_en;
    assign arr_wdata = alloc_en ? merged_line : {BEATS{cpu_req.wdata}};
    assign arr_bmask = alloc_en ? '1
                     : ({{(LINE_BYTES-8){1'b0}}, cpu_req.wmask}
                        << {cpu_req.addr[OFFSET_W-1:3], 3'b000});

    // cpu response
    assign rsp_line       = alloc_en ? line_buf : line_rdata;
    assign cpu_rsp.ready  = ready;
    assign cpu_rsp.rvalid = (state_q == RD_HIT) || (alloc_en && !lat_wr);
    assign cpu_rsp.bvalid = (state_q == WR_HIT);
    assign cpu_rsp.rdata  = rsp_line[lat_beat*BEAT_W +: BEAT_W];

endmodule

`default_nettype wire

// File: source/dcache_axi_master.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_axi_master (
    input  logic                          I_clk,
    input  logic                          I_rst,
    input  logic                          refill_start,
    input  logic [31:0]                   refill_addr,
    input  logic                          wb_start,
    input  logic [31:0]                   wb_addr,
    input  logic [dcache_pkg::LINE_W-1:0] wb_line,
    output logic                          refill_done,
    output logic                          wb_done,
    output logic [dcache_pkg::LINE_W-1:0] line_buf,
    output dcache_pkg::axi_rd_req_t       axi_rd_req,
    input  dcache_pkg::axi_rd_rsp_t       axi_rd_rsp,
    output dcache_pkg::axi_wr_req_t       axi_wr_req,
    input  dcache_pkg::axi_wr_rsp_t       axi_wr_rsp
);
    import dcache_pkg::*;

    logic                     ar_pend;
    logic [31:0]              ar_addr;
    logic [31:0]              aw_addr;
    wb_state_e                wb_state_q;
    wb_state_e                wb_state_d;
    logic [$clog2(BEATS)-1:0] wb_beat;
    logic                     w_fire;

    ////////////////////////////////////////
    // refill read burst
    ////////////////////////////////////////
    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            ar_pend <= 1'b0;
        end else if (refill_start) begin
            ar_pend <= 1'b1;
        end else if (axi_rd_rsp.arready) begin
            ar_pend <= 1'b0;
        end
    end

    always_ff @(posedge I_clk) begin
        if (refill_start) begin
            ar_addr <= refill_addr;
        end
    end

    // beats shift in from the top, first beat ends up lowest
    always_ff @(posedge I_clk) begin
        if (axi_rd_rsp.rvalid) begin
            line_buf <= {axi_rd_rsp.rdata, line_buf[LINE_W-1:BEAT_W]};
        end
    end

    assign refill_done = axi_rd_rsp.rvalid && axi_rd_rsp.rlast;

    assign axi_rd_req.arvalid = ar_pend;
    assign axi_rd_req.araddr  = ar_addr;
    assign axi_rd_req.arlen   = BURST_LEN;
    assign axi_rd_req.arsize  = BURST_SIZE;
    assign axi_rd_req.arburst = BURST_INCR;
    assign axi_rd_req.rready  = 1'b1;

    ////////////////////////////////////////
    // victim write-back burst
    ////////////////////////////////////////
    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            wb_state_q <= WB_IDLE;
        end else begin
            wb_state_q <= wb_state_d;
        end
    end

    always_comb begin
        wb_state_d = wb_state_q;
        case (wb_state_q)
            WB_IDLE: wb_state_d = wb_start ? WB_AW : WB_IDLE;
            WB_AW:   wb_state_d = axi_wr_rsp.awready ? WB_DATA : WB_AW;
            WB_DATA: wb_state_d = (w_fire && axi_wr_req.wlast) ? WB_RESP : WB_DATA;
            WB_RESP: wb_state_d = axi_wr_rsp.bvalid ? WB_IDLE : WB_RESP;
            default: wb_state_d = WB_IDLE;
        endcase
    end

    always_ff @(posedge I_clk) begin
        if (wb_start) begin
            aw_addr <= wb_addr;
        end
    end

    assign w_fire = axi_wr_req.wvalid && axi_wr_rsp.wready;

    // beat counter wraps back to zero after the last beat
    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            wb_beat <= '0;
        end else if (w_fire) begin
            wb_beat <= wb_beat + 1'b1;
        end
    end

    assign wb_done = (wb_state_q == WB_RESP) && axi_wr_rsp.bvalid;

    assign axi_wr_req.awvalid = (wb_state_q == WB_AW);
    assign axi_wr_req.awaddr  = aw_addr;
    assign axi_wr_req.awlen   = BURST_LEN;
    assign axi_wr_req.awsize  = BURST_SIZE;
    assign axi_wr_req.awburst = BURST_INCR;
    assign axi_wr_req.wvalid  = (wb_state_q == WB_DATA);
    assign axi_wr_req.wdata   = wb_line[wb_beat*BEAT_W +: BEAT_W];
    assign axi_wr_req.wstrb   = '1;
    assign axi_wr_req.wlast   = axi_wr_req.wvalid && (wb_beat == BEATS - 1);
    assign axi_wr_req.bready  = 1'b1;

endmodule

`default_nettype wire

// File: source/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic                    I_clk,
    input  logic                    I_rst,
    input  dcache_pkg::cpu_req_t    cpu_req,
    output dcache_pkg::cpu_rsp_t    cpu_rsp,
    output dcache_pkg::axi_rd_req_t axi_rd_req,
    input  dcache_pkg::axi_rd_rsp_t axi_rd_rsp,
    output dcache_pkg::axi_wr_req_t axi_wr_req,
    input  dcache_pkg::axi_wr_rsp_t axi_wr_rsp
);
    import dcache_pkg::*;

    // tag store results
    logic               hit;
    logic               hit_way;
    logic               victim_way;
    logic               victim_dirty;
    logic [TAG_W-1:0]   victim_tag;
    logic [31:0]        lookup_addr;
    logic [INDEX_W-1:0] op_index;
    logic               op_way;
    logic [TAG_W-1:0]   alloc_tag;
    logic               alloc_en;
    logic               dirty_set;
    logic               dirty_clr;

    // data array port
    logic [INDEX_W-1:0]    arr_addr;
    logic                  arr_way;
    logic                  arr_wen;
    logic [LINE_W-1:0]     arr_wdata;
    logic [LINE_BYTES-1:0] arr_bmask;
    logic [LINE_W-1:0]     arr_rdata;

    // refill and write-back handoff
    logic              refill_start;
    logic [31:0]       refill_addr;
    logic              refill_done;
    logic              wb_start;
    logic [31:0]       wb_addr;
    logic              wb_done;
    logic [LINE_W-1:0] line_buf;

    dcache_ctrl i_ctrl (
        .I_clk        (I_clk),
        .I_rst        (I_rst),
        .cpu_req      (cpu_req),
        .cpu_rsp      (cpu_rsp),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .refill_done  (refill_done),
        .wb_done      (wb_done),
        .line_rdata   (arr_rdata),
        .line_buf     (line_buf),
        .refill_start (refill_start),
        .wb_start     (wb_start),
        .refill_addr  (refill_addr),
        .alloc_en     (alloc_en),
        .dirty_set    (dirty_set),
        .dirty_clr    (dirty_clr),
        .arr_addr     (arr_addr),
        .arr_way      (arr_way),
        .arr_wen      (arr_wen),
        .arr_wdata    (arr_wdata),
        .arr_bmask    (arr_bmask),
        .wb_addr      (wb_addr),
        .victim_tag   (victim_tag),
        .lookup_addr  (lookup_addr),
        .op_index     (op_index),
        .op_way       (op_way),
        .alloc_tag    (alloc_tag)
    );

    dcache_tag_store i_tags (
        .I_clk        (I_clk),
        .I_rst        (I_rst),
        .lookup_addr  (lookup_addr),
        .op_index     (op_index),
        .op_way       (op_way),
        .alloc_tag    (alloc_tag),
        .alloc_en     (alloc_en),
        .dirty_set    (dirty_set),
        .dirty_clr    (dirty_clr),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    dcache_data_array i_data (
        .I_clk (I_clk),
        .addr  (arr_addr),
        .way   (arr_way),
        .wen   (arr_wen),
        .wdata (arr_wdata),
        .bmask (arr_bmask),
        .rdata (arr_rdata)
    );

    // victim line comes straight from the array read port
    dcache_axi_master i_axi (
        .I_clk        (I_clk),
        .I_rst        (I_rst),
        .refill_start (refill_start),
        .refill_addr  (refill_addr),
        .wb_start     (wb_start),
        .wb_addr      (wb_addr),
        .wb_line      (arr_rdata),
        .refill_done  (refill_done),
        .wb_done      (wb_done),
        .line_buf     (line_buf),
        .axi_rd_req   (axi_rd_req),
        .axi_rd_rsp   (axi_rd_rsp),
        .axi_wr_req   (axi_wr_req),
        .axi_wr_rsp   (axi_wr_rsp)
    );

endmodule

`default_nettype wire

// File: verif/dcache_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_model (
    input  logic                    I_clk,
    input  logic                    I_rst,
    input  dcache_pkg::axi_rd_req_t axi_rd_req,
    output dcache_pkg::axi_rd_rsp_t axi_rd_rsp,
    input  dcache_pkg::axi_wr_req_t axi_wr_req,
    output dcache_pkg::axi_wr_rsp_t axi_wr_rsp,
    output int                      rd_bursts,
    output int                      wr_bursts,
    output int                      bus_errs
);
    import dcache_pkg::*;

    // bytes written back so far, everything else reads as the fill pattern
    logic [7:0]  store [logic [31:0]];
    logic [31:0] rng_state;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        return a[7:0] + a[15:8] + a[23:16] + a[31:24];
    endfunction

    function automatic logic [63:0] read_beat(input logic [31:0] a);
        logic [63:0] beat;
        logic [31:0] ba;
        for (int b = 0; b < 8; b++) begin
            ba = {a[31:3], b[2:0]};
            beat[8*b +: 8] = store.exists(ba) ? store[ba] : fill_byte(ba);
        end
        return beat;
    endfunction

    // 0 to 3 idle cycles before a ready
    task automatic stall_cycles();
        rng_state = xorshift(rng_state);
        repeat (rng_state[1:0]) begin
            @(posedge I_clk);
            #1;
        end
    endtask

    task automatic check_burst(input string kind, input logic [31:0] addr,
                               input logic [7:0] len, input logic [2:0] size,
                               input logic [1:0] burst);
        if (len != 8'd3 || size != 3'd3 || burst != 2'd1) begin
            bus_errs++;
            $display("%s burst at %h has len %0d, size %0d, type %0d instead of 3, 3, INCR",
                     kind, addr, len, size, burst);
        end
        if (addr[4:0] != 5'd0) begin
            bus_errs++;
            $display("%s burst address %h is not aligned to a line", kind, addr);
        end
    endtask

    task automatic read_burst();
        logic [31:0] addr;
        stall_cycles();
        axi_rd_rsp.arready = 1'b1;
        addr = axi_rd_req.araddr;
        check_burst("read", addr, axi_rd_req.arlen, axi_rd_req.arsize, axi_rd_req.arburst);
        rd_bursts++;
        @(posedge I_clk);
        #1;
        axi_rd_rsp.arready = 1'b0;
        for (int i = 0; i < 4; i++) begin
            axi_rd_rsp.rvalid = 1'b1;
            axi_rd_rsp.rdata  = read_beat({addr[31:5], i[1:0], 3'b000});
            axi_rd_rsp.rlast  = (i == 3);
            if (!axi_rd_req.rready) begin
                bus_errs++;
                $display("read beat %0d at %h was sent while rready was low", i, addr);
            end
            @(posedge I_clk);
            #1;
        end
        axi_rd_rsp.rvalid = 1'b0;
        axi_rd_rsp.rlast  = 1'b0;
    endtask

    task automatic write_burst();
        logic [31:0] addr;
        stall_cycles();
        axi_wr_rsp.awready = 1'b1;
        addr = axi_wr_req.awaddr;
        check_burst("write", addr, axi_wr_req.awlen, axi_wr_req.awsize, axi_wr_req.awburst);
        @(posedge I_clk);
        #1;
        axi_wr_rsp.awready = 1'b0;
        for (int i = 0; i < 4; i++) begin
            stall_cycles();
            axi_wr_rsp.wready = 1'b1;
            if (!axi_wr_req.wvalid || axi_wr_req.wstrb != 8'hff
                || axi_wr_req.wlast != (i == 3)) begin
                bus_errs++;
                $display("write beat %0d at %h is wrong: wvalid %b, wstrb %h, wlast %b",
                         i, addr, axi_wr_req.wvalid, axi_wr_req.wstrb, axi_wr_req.wlast);
            end
            for (int b = 0; b < 8; b++) begin
                store[{addr[31:5], i[1:0], b[2:0]}] = axi_wr_req.wdata[8*b +: 8];
            end
            @(posedge I_clk);
            #1;
            axi_wr_rsp.wready = 1'b0;
        end
        axi_wr_rsp.bvalid = 1'b1;
        if (!axi_wr_req.bready) begin
            bus_errs++;
            $display("write response at %h was sent while bready was low", addr);
        end
        wr_bursts++;
        @(posedge I_clk);
        #1;
        axi_wr_rsp.bvalid = 1'b0;
    endtask

    ////////////////////////////////////////
    // serves one burst at a time since refill and write-back never overlap
    ////////////////////////////////////////
    initial begin
        axi_rd_rsp = '0;
        axi_wr_rsp = '0;
        rd_bursts  = 0;
        wr_bursts  = 0;
        bus_errs   = 0;
        rng_state  = 32'hd6582eb8;
        forever begin
            @(posedge I_clk);
            #1;
            if (!I_rst && axi_rd_req.arvalid) begin
                read_burst();
            end else if (!I_rst && axi_wr_req.awvalid) begin
                write_burst();
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    typedef struct {
        string       name;
        bit          wr;
        logic [31:0] addr;
        logic [63:0] wdata;
        logic [7:0]  wmask;
        bit          exp_hit;
        int          exp_wb;
    } step_t;

    logic        I_clk;
    logic        I_rst;
    cpu_req_t    cpu_req;
    cpu_rsp_t    cpu_rsp;
    axi_rd_req_t axi_rd_req;
    axi_rd_rsp_t axi_rd_rsp;
    axi_wr_req_t axi_wr_req;
    axi_wr_rsp_t axi_wr_rsp;
    int          rd_bursts;
    int          wr_bursts;
    int          bus_errs;
    int          data_errs;
    int          path_errs;

    step_t       steps[$];
    logic [7:0]  shadow [logic [31:0]];

    dcache_top i_dut (
        .I_clk      (I_clk),
        .I_rst      (I_rst),
        .cpu_req    (cpu_req),
        .cpu_rsp    (cpu_rsp),
        .axi_rd_req (axi_rd_req),
        .axi_rd_rsp (axi_rd_rsp),
        .axi_wr_req (axi_wr_req),
        .axi_wr_rsp (axi_wr_rsp)
    );

    dcache_mem_model i_mem (
        .I_clk      (I_clk),
        .I_rst      (I_rst),
        .axi_rd_req (axi_rd_req),
        .axi_rd_rsp (axi_rd_rsp),
        .axi_wr_req (axi_wr_req),
        .axi_wr_rsp (axi_wr_rsp),
        .rd_bursts  (rd_bursts),
        .wr_bursts  (wr_bursts),
        .bus_errs   (bus_errs)
    );

    always #50 I_clk = ~I_clk;

    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        return a[7:0] + a[15:8] + a[23:16] + a[31:24];
    endfunction

    function automatic logic [63:0] shadow_beat(input logic [31:0] a);
        logic [63:0] beat;
        logic [31:0] ba;
        for (int b = 0; b < 8; b++) begin
            ba = {a[31:3], b[2:0]};
            beat[8*b +: 8] = shadow.exists(ba) ? shadow[ba] : fill_byte(ba);
        end
        return beat;
    endfunction

    task automatic shadow_write(input logic [31:0] a, input logic [63:0] d,
                                input logic [7:0] m);
        for (int b = 0; b < 8; b++) begin
            if (m[b]) begin
                shadow[{a[31:3], b[2:0]}] = d[8*b +: 8];
            end
        end
    endtask

    task automatic add_step(input string name, input bit wr, input logic [31:0] addr,
                            input logic [63:0] wdata, input logic [7:0] wmask,
                            input bit exp_hit, input int exp_wb);
        step_t s;
        s.name    = name;
        s.wr      = wr;
        s.addr    = addr;
        s.wdata   = wdata;
        s.wmask   = wmask;
        s.exp_hit = exp_hit;
        s.exp_wb  = exp_wb;
        steps.push_back(s);
    endtask

    ////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////
    // set 2 holds lines at 0x8000_0040, 0x8000_1040, 0x8000_2040, 0x8000_3040
    task automatic build_table();
        add_step("rd_miss_a",   1'b0, 32'h8000_0048, 64'h0, 8'h00, 1'b0, 0);
        add_step("rd_hit_a",    1'b0, 32'h8000_0050, 64'h0, 8'h00, 1'b1, 0);
        add_step("wr_hit_a",    1'b1, 32'h8000_0050, 64'h1122_3344_5566_7788, 8'h0f, 1'b1, 0);
        add_step("rd_merge_a",  1'b0, 32'h8000_0050, 64'h0, 8'h00, 1'b1, 0);
        add_step("wr_miss_c",   1'b1, 32'h8000_0138, 64'hdead_beef_cafe_f00d, 8'hf0, 1'b0, 0);
        add_step("rd_other_c",  1'b0, 32'h8000_0120, 64'h0, 8'h00, 1'b1, 0);
        add_step("rd_merge_c",  1'b0, 32'h8000_0138, 64'h0, 8'h00, 1'b1, 0);
        add_step("rd_miss_b",   1'b0, 32'h8000_1040, 64'h0, 8'h00, 1'b0, 0);
        add_step("rd_evict_a",  1'b0, 32'h8000_2058, 64'h0, 8'h00, 1'b0, 1);
        add_step("rd_back_a",   1'b0, 32'h8000_0050, 64'h0, 8'h00, 1'b0, 0);
        add_step("wr_hit_b",    1'b1, 32'h8000_1040, 64'h0123_4567_89ab_cdef, 8'hff, 1'b1, 0);
        add_step("rd_hit_b",    1'b0, 32'h8000_1040, 64'h0, 8'h00, 1'b1, 0);
        add_step("wr_miss_e",   1'b1, 32'h8000_3048, 64'h5a5a_a5a5_0f0f_f0f0, 8'h81, 1'b0, 0);
        add_step("rd_evict_e",  1'b0, 32'h8000_0058, 64'h0, 8'h00, 1'b0, 1);
        add_step("rd_back_e",   1'b0, 32'h8000_3048, 64'h0, 8'h00, 1'b0, 0);
        add_step("rd_keep_b",   1'b0, 32'h8000_1040, 64'h0, 8'h00, 1'b1, 0);
    endtask

    task automatic run_step(input step_t s);
        int          rd_before;
        int          wr_before;
        int          lat;
        logic [63:0] expected;
        @(posedge I_clk);
        #1;
        rd_before     = rd_bursts;
        wr_before     = wr_bursts;
        cpu_req.rd    = ~s.wr;
        cpu_req.wr    = s.wr;
        cpu_req.addr  = s.addr;
        cpu_req.wdata = s.wdata;
        cpu_req.wmask = s.wmask;
        @(negedge I_clk);
        while (!cpu_rsp.ready) begin
            @(negedge I_clk);
        end
        // accepted on the next edge
        @(posedge I_clk);
        #1;
        cpu_req = '0;
        lat = 1;
        @(negedge I_clk);
        while (!cpu_rsp.rvalid && !cpu_rsp.bvalid) begin
            @(negedge I_clk);
            lat++;
        end
        if (cpu_rsp.rvalid == s.wr || cpu_rsp.bvalid != s.wr) begin
            path_errs++;
            $display("%s ended with the wrong response, rvalid %b bvalid %b",
                     s.name, cpu_rsp.rvalid, cpu_rsp.bvalid);
        end
        if (s.exp_hit && lat != 1) begin
            path_errs++;
            $display("Mismatch %s latency: expected 1, actual %0d", s.name, lat);
        end
        if (rd_bursts - rd_before != (s.exp_hit ? 0 : 1)) begin
            path_errs++;
            $display("Mismatch %s refills: expected %0d, actual %0d",
                     s.name, s.exp_hit ? 0 : 1, rd_bursts - rd_before);
        end
        if (wr_bursts - wr_before != s.exp_wb) begin
            path_errs++;
            $display("Mismatch %s write-backs: expected %0d, actual %0d",
                     s.name, s.exp_wb, wr_bursts - wr_before);
        end
        if (s.wr) begin
            shadow_write(s.addr, s.wdata, s.wmask);
        end else begin
            expected = shadow_beat(s.addr);
            if (cpu_rsp.rdata !== expected) begin
                data_errs++;
                $display("Mismatch %s: expected %h, actual %h", s.name, expected, cpu_rsp.rdata);
            end
        end
    endtask

    initial begin
        I_clk     = 1'b0;
        I_rst     = 1'b1;
        cpu_req   = '0;
        data_errs = 0;
        path_errs = 0;
        build_table();
        repeat (5) @(posedge I_clk);
        #1;
        I_rst = 1'b0;
        @(negedge I_clk);
        if (!cpu_rsp.ready || cpu_rsp.rvalid || cpu_rsp.bvalid || axi_rd_req.arvalid
            || axi_wr_req.awvalid || axi_wr_req.wvalid) begin
            path_errs++;
            $display("outputs are not in their idle state after reset");
        end
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        $display("errors: data %0d, path %0d, bus %0d", data_errs, path_errs, bus_errs);
        if (data_errs + path_errs + bus_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // watchdog, 60 cycles per table entry plus reset
    initial begin
        #1;
        repeat (steps.size() * 60 + 5) @(posedge I_clk);
        $display("Timeout: the tests did not finish within %0d cycles", steps.size() * 60 + 5);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
source/dcache_pkg.sv
source/dcache_tag_store.sv
source/dcache_data_array.sv
source/dcache_ctrl.sv
source/dcache_axi_master.sv
source/dcache_top.sv
verif/dcache_mem_model.sv
verif/tb_dcache.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_dcache -f build.f -o sim_dcache

out=$(./obj_dir/sim_dcache)
echo "$out"
echo "$out" | grep -q "TEST RESULT: PASS"
